// ==== source/tomasulo_pkg.sv ====
`default_nettype none

package tomasulo_pkg;

    localparam int XLEN          = 32;
    localparam int RS_ENTRIES    = 4;
    localparam int RS_IDX_W      = $clog2(RS_ENTRIES);
    localparam int ROB_ENTRIES   = 16;
    localparam int ROB_TAG_W     = $clog2(ROB_ENTRIES);
    // port 0 is the cluster's own result, port 1 the other units
    localparam int NUM_CDB_PORTS = 2;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // value is meaningful only when ready, otherwise tag names the producer
    typedef struct packed {
        logic            ready;
        rob_tag_t        tag;
        logic [XLEN-1:0] value;
    } operand_t;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        operand_t rs1;
        operand_t rs2;
        rob_tag_t dest;
    } alu_dispatch_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [XLEN-1:0] value;
    } cdb_entry_t;

    typedef cdb_entry_t [NUM_CDB_PORTS-1:0] cdb_bus_t;

    // completed but not yet committed results
    typedef struct packed {
        logic [ROB_ENTRIES-1:0]           done;
        logic [ROB_ENTRIES-1:0][XLEN-1:0] value;
    } rob_status_t;

    // pick up a waiting operand from any matching broadcast
    function automatic operand_t cdb_capture(operand_t src, cdb_bus_t bus);
        operand_t res;
        res = src;
        for (int p = 0; p < NUM_CDB_PORTS; p++) begin
            if (!res.ready && bus[p].valid && bus[p].tag == src.tag) begin
                res.ready = 1'b1;
                res.value = bus[p].value;
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== source/operand_resolve.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_resolve (
    input  tomasulo_pkg::alu_dispatch_t dispatch_i,
    input  tomasulo_pkg::rob_status_t   rob_i,
    input  tomasulo_pkg::cdb_bus_t      cdb_bus_i,
    output tomasulo_pkg::alu_dispatch_t resolved_o
);
    import tomasulo_pkg::*;

    // a same-cycle broadcast wins over the reorder buffer copy
    function automatic operand_t resolve_src(
        operand_t    src,
        cdb_bus_t    bus,
        rob_status_t rob
    );
        operand_t res;
        res = cdb_capture(src, bus);
        if (!res.ready && rob.done[src.tag]) begin
            res.ready = 1'b1;
            res.value = rob.value[src.tag];
        end
        return res;
    endfunction

    always_comb begin
        resolved_o     = dispatch_i;
        resolved_o.rs1 = resolve_src(dispatch_i.rs1, cdb_bus_i, rob_i);
        resolved_o.rs2 = resolve_src(dispatch_i.rs2, cdb_bus_i, rob_i);
    end

endmodule

`default_nettype wire

// ==== source/alu_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          clear_i,
    input  logic                          start_i,
    input  tomasulo_pkg::alu_op_e         op_i,
    input  logic [tomasulo_pkg::XLEN-1:0] a_i,
    input  logic [tomasulo_pkg::XLEN-1:0] b_i,
    input  tomasulo_pkg::rob_tag_t        tag_i,
    output tomasulo_pkg::cdb_entry_t      result_o
);
    import tomasulo_pkg::*;

    logic [XLEN-1:0] alu_res;
    logic [4:0]      shamt;
    logic            valid_q;
    rob_tag_t        tag_q;
    logic [XLEN-1:0] value_q;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  alu_res = a_i + b_i;
            ALU_SUB:  alu_res = a_i - b_i;
            ALU_SLL:  alu_res = a_i << shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, a_i < b_i};
            ALU_XOR:  alu_res = a_i ^ b_i;
            ALU_SRL:  alu_res = a_i >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(a_i) >>> shamt);
            ALU_OR:   alu_res = a_i | b_i;
            ALU_AND:  alu_res = a_i & b_i;
            default:  alu_res = '0;
        endcase
    end

    // result stays valid until the arbiter takes it
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end else if (start_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            tag_q   <= tag_i;
            value_q <= alu_res;
        end
    end

    assign result_o = '{valid: valid_q, tag: tag_q, value: value_q};

endmodule

`default_nettype wire

// ==== source/alu_rs.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_rs (
    input  logic                                                   clk,
    input  logic                                                   arst_n_i,
    input  logic                                                   flush_i,
    input  tomasulo_pkg::alu_dispatch_t                            dispatch_i,
    input  tomasulo_pkg::cdb_bus_t                                 cdb_bus_i,
    input  logic [tomasulo_pkg::RS_ENTRIES-1:0]                    take_i,
    output tomasulo_pkg::cdb_entry_t [tomasulo_pkg::RS_ENTRIES-1:0] result_o,
    output logic                                                   credit_o
);
    import tomasulo_pkg::*;

    alu_dispatch_t           entries_q [RS_ENTRIES];
    logic [RS_ENTRIES-1:0] busy_q;
    logic [RS_ENTRIES-1:0] fired_q;
    // registered start, one cycle after the entry turns ready
    logic [RS_ENTRIES-1:0] fire_q;
    logic [RS_ENTRIES-1:0] alloc_oh;
    logic [RS_ENTRIES-1:0] ready_mask;
    logic                  credit_q;

    // lowest free entry, credits guarantee one exists on dispatch
    always_comb begin
        alloc_oh = '0;
        for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                alloc_oh    = '0;
                alloc_oh[i] = 1'b1;
            end
        end
        if (!dispatch_i.valid || flush_i) begin
            alloc_oh = '0;
        end
    end

    always_comb begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            ready_mask[i] = busy_q[i] && !fired_q[i]
                            && entries_q[i].rs1.ready && entries_q[i].rs2.ready;
        end
    end

    // operand storage, waiting entries listen to every broadcast
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            if (alloc_oh[i]) begin
                entries_q[i] <= dispatch_i;
            end else begin
                entries_q[i].rs1 <= cdb_capture(entries_q[i].rs1, cdb_bus_i);
                entries_q[i].rs2 <= cdb_capture(entries_q[i].rs2, cdb_bus_i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q   <= '0;
            fired_q  <= '0;
            fire_q   <= '0;
            credit_q <= 1'b0;
        end else if (flush_i) begin
            busy_q   <= '0;
            fired_q  <= '0;
            fire_q   <= '0;
            credit_q <= 1'b0;
        end else begin
            busy_q   <= (busy_q & ~take_i) | alloc_oh;
            fired_q  <= (fired_q | ready_mask) & ~take_i;
            fire_q   <= ready_mask;
            // arbiter takes at most one entry per cycle
            credit_q <= |take_i;
        end
    end

    // a pulse still pending when the flush hits is dropped
    assign credit_o = credit_q & ~flush_i;

    for (genvar g = 0; g < RS_ENTRIES; g++) begin : g_alu
        alu_unit u_alu (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .clear_i  (take_i[g] | flush_i),
            .start_i  (fire_q[g]),
            .op_i     (entries_q[g].op),
            .a_i      (entries_q[g].rs1.value),
            .b_i      (entries_q[g].rs2.value),
            .tag_i    (entries_q[g].dest),
            .result_o (result_o[g])
        );
    end

endmodule

`default_nettype wire

// ==== source/cdb_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module cdb_arbiter (
    input  logic                                                   clk,
    input  logic                                                   arst_n_i,
    input  logic                                                   flush_i,
    input  tomasulo_pkg::cdb_entry_t [tomasulo_pkg::RS_ENTRIES-1:0] results_i,
    input  logic                                                   grant_i,
    output tomasulo_pkg::cdb_entry_t                               cdb_o,
    output logic [tomasulo_pkg::RS_ENTRIES-1:0]                    take_o
);
    import tomasulo_pkg::*;

    // last granted entry
    logic [RS_IDX_W-1:0] ptr_q;
    logic                hold_q;
    logic [RS_IDX_W-1:0] hold_idx_q;
    logic [RS_IDX_W-1:0] rr_idx;
    logic [RS_IDX_W-1:0] sel_idx;
    logic                rr_found;

    // search starts just after the last winner
    always_comb begin
        logic [RS_IDX_W-1:0] cand;
        rr_found = 1'b0;
        rr_idx   = '0;
        for (int k = 1; k <= RS_ENTRIES; k++) begin
            cand = ptr_q + RS_IDX_W'(k);
            if (!rr_found && results_i[cand].valid) begin
                rr_found = 1'b1;
                rr_idx   = cand;
            end
        end
    end

    // a stalled choice is held so cdb_o stays stable
    assign sel_idx = hold_q ? hold_idx_q : rr_idx;

    always_comb begin
        cdb_o       = results_i[sel_idx];
        cdb_o.valid = results_i[sel_idx].valid & ~flush_i;
        take_o      = '0;
        if (cdb_o.valid && grant_i) begin
            take_o[sel_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q      <= RS_IDX_W'(RS_ENTRIES - 1);
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else if (flush_i) begin
            hold_q <= 1'b0;
        end else if (cdb_o.valid) begin
            if (grant_i) begin
                ptr_q  <= sel_idx;
                hold_q <= 1'b0;
            end else begin
                hold_q     <= 1'b1;
                hold_idx_q <= sel_idx;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/alu_cluster_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_cluster_top (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        flush_i,
    input  tomasulo_pkg::alu_dispatch_t dispatch_i,
    input  tomasulo_pkg::rob_status_t   rob_i,
    input  tomasulo_pkg::cdb_entry_t    cdb_i,
    input  logic                        cdb_grant_i,
    output tomasulo_pkg::cdb_entry_t    cdb_o,
    output logic                        credit_o
);
    import tomasulo_pkg::*;

    alu_dispatch_t                resolved;
    cdb_bus_t                     cdb_bus;
    cdb_entry_t                   own_bcast;
    cdb_entry_t [RS_ENTRIES-1:0] alu_results;
    logic [RS_ENTRIES-1:0]       take;

    // only a granted result counts as broadcast for wakeup
    assign own_bcast = '{valid: cdb_o.valid & cdb_grant_i, tag: cdb_o.tag, value: cdb_o.value};
    assign cdb_bus[0] = own_bcast;
    assign cdb_bus[1] = cdb_i;

    operand_resolve u_resolve (
        .dispatch_i (dispatch_i),
        .rob_i      (rob_i),
        .cdb_bus_i  (cdb_bus),
        .resolved_o (resolved)
    );

    alu_rs u_rs (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .dispatch_i (resolved),
        .cdb_bus_i  (cdb_bus),
        .take_i     (take),
        .result_o   (alu_results),
        .credit_o   (credit_o)
    );

    cdb_arbiter u_arb (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .flush_i   (flush_i),
        .results_i (alu_results),
        .grant_i   (cdb_grant_i),
        .cdb_o     (cdb_o),
        .take_o    (take)
    );

endmodule

`default_nettype wire

// ==== tests/tomasulo_alu_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module tomasulo_alu_sva (
    input logic                        clk,
    input logic                        arst_n_i,
    input logic                        flush_i,
    input tomasulo_pkg::alu_dispatch_t dispatch_i,
    input tomasulo_pkg::cdb_entry_t    cdb_o,
    input logic                        cdb_grant_i,
    input logic                        credit_o
);
    import tomasulo_pkg::*;

    // credits held by the decoder
    int credit_cnt;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt <= RS_ENTRIES;
        end else if (flush_i) begin
            credit_cnt <= RS_ENTRIES;
        end else begin
            credit_cnt <= credit_cnt - int'(dispatch_i.valid) + int'(credit_o);
        end
    end

    cdb_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        cdb_o.valid && !cdb_grant_i |=> $stable(cdb_o) || flush_i)
        else $error("cdb_o changed while not granted");

    flush_quiet_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> !credit_o && !cdb_o.valid)
        else $error("credit or result seen right after flush");

    credit_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        dispatch_i.valid |-> credit_cnt > 0)
        else $error("dispatch without a credit");

endmodule

bind alu_cluster_top tomasulo_alu_sva sva_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush_i),
    .dispatch_i  (dispatch_i),
    .cdb_o       (cdb_o),
    .cdb_grant_i (cdb_grant_i),
    .credit_o    (credit_o)
);

`default_nettype wire

// ==== tests/tb_tomasulo_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_tomasulo_alu;
    import tomasulo_pkg::*;

    // roughly four times the length of all tests together
    localparam int MAX_CYCLES = 2000;

    logic          clk;
    logic          arst_n_i;
    logic          flush_i;
    alu_dispatch_t dispatch_i;
    rob_status_t   rob_i;
    cdb_entry_t    cdb_i;
    logic          cdb_grant_i;
    cdb_entry_t    cdb_o;
    logic          credit_o;

    integer                 seed = 32'he4dd857f;
    int                     credits = RS_ENTRIES;
    int                     cycles = 0;
    int                     errors = 0;
    int                     n_grant = 0;
    int                     n_credit = 0;
    int                     n_results = 0;
    // 0 random grant, 1 grant held low, 2 grant held high
    int                     grant_mode = 0;
    logic [ROB_ENTRIES-1:0] pending = '0;
    logic [XLEN-1:0]        golden [ROB_ENTRIES];
    rob_status_t            rob_model = '0;

    alu_cluster_top dut_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .dispatch_i  (dispatch_i),
        .rob_i       (rob_i),
        .cdb_i       (cdb_i),
        .cdb_grant_i (cdb_grant_i),
        .cdb_o       (cdb_o),
        .credit_o    (credit_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // mode is taken at the edge so a test change applies from the next cycle
    always @(posedge clk) begin
        int mode_now;
        int rnd;
        mode_now = grant_mode;
        #1;
        rnd = $random(seed);
        cdb_grant_i = (mode_now == 0) ? rnd[0] : (mode_now == 2);
    end

    always @(posedge clk) begin
        #2;
        rob_i = rob_model;
    end

    // decoder credit counter
    always @(negedge clk) begin
        if (flush_i) begin
            credits = RS_ENTRIES;
        end else begin
            credits = credits - int'(dispatch_i.valid) + int'(credit_o);
        end
        if (credit_o) begin
            n_credit++;
        end
    end

    // compare every granted result, and record broadcasts in the rob model
    always @(negedge clk) begin
        if (arst_n_i && cdb_o.valid && cdb_grant_i) begin
            n_grant++;
            n_results++;
            if (!pending[cdb_o.tag]) begin
                $display("Error at %0t ns: tag %0d on cdb_o was not expected", $time, cdb_o.tag);
                errors++;
            end else if (cdb_o.value !== golden[cdb_o.tag]) begin
                $display("** Error at %0t ns: cdb_o.value for tag %0d is %h, expected %h",
                         $time, cdb_o.tag, cdb_o.value, golden[cdb_o.tag]);
                errors++;
            end
            pending[cdb_o.tag]         = 1'b0;
            rob_model.done[cdb_o.tag]  = 1'b1;
            rob_model.value[cdb_o.tag] = cdb_o.value;
        end
        if (arst_n_i && cdb_i.valid) begin
            rob_model.done[cdb_i.tag]  = 1'b1;
            rob_model.value[cdb_i.tag] = cdb_i.value;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [XLEN-1:0] ref_alu(alu_op_e op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
        int sh;
        // RV32I shifts use the low five bits of rs2
        sh = int'(b[4:0]);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            // vacated upper bits take the sign of rs1
            ALU_SRA:  return (a >> sh) | ({XLEN{a[XLEN-1]}} & ~({XLEN{1'b1}} >> sh));
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return 32'h0;
        endcase
    endfunction

    // negative src means a ready value, otherwise the producer tag
    function automatic operand_t make_operand(int src, logic [XLEN-1:0] v);
        if (src < 0) begin
            return '{ready: 1'b1, tag: '0, value: v};
        end
        return '{ready: 1'b0, tag: rob_tag_t'(src), value: '0};
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_credit();
        while (credits == 0) begin
            step();
        end
    endtask

    task automatic dispatch(input alu_op_e op, input int dest, input int src1, input int src2,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        alu_dispatch_t d;
        logic [XLEN-1:0] va;
        logic [XLEN-1:0] vb;
        wait_credit();
        va = (src1 < 0) ? a : golden[src1];
        vb = (src2 < 0) ? b : golden[src2];
        d.valid = 1'b1;
        d.op    = op;
        d.rs1   = make_operand(src1, a);
        d.rs2   = make_operand(src2, b);
        d.dest  = rob_tag_t'(dest);
        golden[dest]  = ref_alu(op, va, vb);
        pending[dest] = 1'b1;
        dispatch_i = d;
        step();
        dispatch_i = '0;
    endtask

    task automatic drain();
        while (pending != '0 || credits != RS_ENTRIES) begin
            step();
        end
    endtask

    // output stalled, result held and no credit back
    task automatic check_stall(input int n);
        cdb_entry_t held;
        @(negedge clk);
        while (!cdb_o.valid) begin
            @(negedge clk);
        end
        held = cdb_o;
        repeat (n) begin
            @(negedge clk);
            if (cdb_o !== held) begin
                $display("** Error at %0t ns: cdb_o is %h, expected %h", $time, cdb_o, held);
                errors++;
            end
            if (credit_o || credits != 0) begin
                $display("Error at %0t ns: a credit came back while the output stalled", $time);
                errors++;
            end
        end
        step();
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            if (credit_o || cdb_o.valid) begin
                $display("Error at %0t ns: credit or result seen during or after a flush", $time);
                errors++;
            end
        end
        step();
    endtask

    task automatic check_credits();
        if (n_credit != n_grant) begin
            $display("** Error at %0t ns: credit_o pulse count %0d, expected %0d",
                     $time, n_credit, n_grant);
            errors++;
        end
    endtask

    // every result is now committed, so the rob forgets them
    task automatic end_test(input string name, input int err0);
        $display("%s: finished with %0d errors", name, errors - err0);
        rob_model.done = '0;
    endtask

    initial begin
        int err0;
        arst_n_i    = 1'b0;
        flush_i     = 1'b0;
        dispatch_i  = '0;
        rob_i       = '0;
        cdb_i       = '0;
        cdb_grant_i = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        step();

        err0 = errors;
        for (int i = 0; i < 10; i++) begin
            dispatch(alu_op_e'(i), i, -1, -1, $random(seed), $random(seed));
        end
        drain();
        end_test("independent ops", err0);

        err0 = errors;
        golden[12] = $random(seed);
        golden[13] = $random(seed);
        dispatch(ALU_ADD, 0, -1, -1, $random(seed), $random(seed));
        dispatch(ALU_SUB, 1, 0, -1, 0, $random(seed));
        dispatch(ALU_XOR, 2, 1, 12, 0, 0);
        dispatch(ALU_SLL, 3, 2, 0, 0, 0);
        cdb_i = '{valid: 1'b1, tag: rob_tag_t'(12), value: golden[12]};
        step();
        cdb_i = '0;
        // broadcast of tag 13 lands in the dispatch cycle of its consumer
        wait_credit();
        cdb_i = '{valid: 1'b1, tag: rob_tag_t'(13), value: golden[13]};
        dispatch(ALU_SRL, 4, 13, 3, 0, 0);
        cdb_i = '0;
        drain();
        end_test("dependency wakeup", err0);

        err0 = errors;
        for (int t = 10; t < 12; t++) begin
            golden[t]          = $random(seed);
            rob_model.value[t] = golden[t];
            rob_model.done[t]  = 1'b1;
        end
        dispatch(ALU_OR, 0, 10, 11, 0, 0);
        dispatch(ALU_SRA, 1, 10, -1, 0, $random(seed));
        dispatch(ALU_SLTU, 2, -1, 11, $random(seed), 0);
        drain();
        end_test("rob forwarding", err0);

        err0 = errors;
        grant_mode = 1;
        n_grant    = 0;
        n_credit   = 0;
        for (int i = 0; i < RS_ENTRIES; i++) begin
            dispatch(ALU_ADD, i, -1, -1, $random(seed), $random(seed));
        end
        check_stall(8);
        grant_mode = 0;
        dispatch(ALU_AND, 4, -1, -1, $random(seed), $random(seed));
        dispatch(ALU_SUB, 5, 1, 4, 0, 0);
        drain();
        check_credits();
        end_test("back-pressure", err0);

        err0 = errors;
        grant_mode = 1;
        for (int i = 0; i < RS_ENTRIES; i++) begin
            dispatch(ALU_XOR, i, -1, -1, $random(seed), $random(seed));
        end
        while (!cdb_o.valid) begin
            step();
        end
        // one grant lands just before the flush, so its credit pulse is still pending
        grant_mode = 2;
        repeat (2) step();
        flush_i = 1'b1;
        pending = '0;
        check_quiet(1);
        flush_i  = 1'b0;
        n_grant  = 0;
        n_credit = 0;
        check_quiet(4);
        grant_mode = 0;
        for (int i = 8; i < 12; i++) begin
            dispatch(alu_op_e'(i - 4), i, -1, -1, $random(seed), $random(seed));
        end
        drain();
        check_credits();
        end_test("flush", err0);

        $display("all tests done: %0d results checked, %0d errors", n_results, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tomasulo_alu.f ====
source/tomasulo_pkg.sv
source/operand_resolve.sv
source/alu_unit.sv
source/alu_rs.sv
source/cdb_arbiter.sv
source/alu_cluster_top.sv
tests/tomasulo_alu_sva.sv
tests/tb_tomasulo_alu.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the ALU cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tomasulo_alu.f \
    --top-module tb_tomasulo_alu \
    -o sim_tomasulo_alu

./obj_dir/sim_tomasulo_alu | tee sim.log

# the run passes only if the testbench reported success
grep -q "Verification passed" sim.log
